// File: Bender.yml
package:
  name: floatconv

sources:
  # package first, then the leaf modules, then the top level.
  - verilog/FloatConvPkg.sv
  - verilog/Shift32U.sv
  - verilog/LeadZero32.sv
  - verilog/IntToFloat.sv
  - verilog/FloatToInt.sv
  - verilog/FloatConv.sv

  - target: simulation
    files:
      - sim/FloatConvTb.sv

// File: FloatConv.f
verilog/FloatConvPkg.sv
verilog/Shift32U.sv
verilog/LeadZero32.sv
verilog/IntToFloat.sv
verilog/FloatToInt.sv
verilog/FloatConv.sv
sim/FloatConvTb.sv

// File: sim/FloatConvTb.sv
`timescale 1ns/1ns

module FloatConvTb;

    import FloatConvPkg::*;

    // about 400 cycles of tests fit well inside this.
    localparam int CycleLimit = 2000;

    logic       clock;
    logic       reset;
    logic       inValid;
    ConvRequest request;
    logic       outValid;
    ConvResult  result;

    ConvResult  expectQueue[$];
    ConvResult  expected;
    ConvResult  lastResult;
    logic [1:0] validHistory;
    int         cycleCount;
    integer     seed;

    FloatConv u_dut (
        .clock    (clock),
        .reset    (reset),
        .inValid  (inValid),
        .request  (request),
        .outValid (outValid),
        .result   (result)
    );

    always #5 clock = ~clock;

    // ########################################
    // failure reporting
    // ########################################

    task automatic stopWithFailure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] want,
                                  input logic [63:0] got);
        $display("[FAIL] %s expected 0x%h got 0x%h", name, want, got);
        stopWithFailure();
    endtask

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            stopWithFailure();
        end
    end

    // ########################################
    // reference model
    // ########################################

    function automatic ConvResult makeResult(input word32T value, input logic invalid,
                                             input logic inexact);
        ConvResult r;
        r.value   = value;
        r.invalid = invalid;
        r.inexact = inexact;
        return r;
    endfunction

    function automatic ConvResult modelIntToFloat(input word32T x);
        ConvResult   r;
        logic        sign;
        logic [31:0] mag;
        logic [31:0] lowMask;
        int          top;
        int          i;
        r = '0;
        if (x != 32'd0) begin
            sign = x[31];
            mag  = sign ? (32'd0 - x) : x;
            top  = 0;
            for (i = 0; i < 32; i++) begin
                if (mag[i]) begin
                    top = i;
                end
            end
            // bring the top one bit to position 23, then drop it as the hidden bit.
            if (top > 23) begin
                lowMask   = (32'd1 << (top - 23)) - 32'd1;
                r.value   = {sign, 8'(127 + top), 23'(mag >> (top - 23))};
                r.inexact = (mag & lowMask) != 32'd0;
            end else begin
                r.value = {sign, 8'(127 + top), 23'(mag << (23 - top))};
            end
        end
        return r;
    endfunction

    function automatic ConvResult modelFloatToInt(input word32T x);
        ConvResult   r;
        logic        sign;
        int          e;
        logic [22:0] f;
        logic [63:0] sig;
        logic [63:0] mag;
        int          k;
        r    = '0;
        sign = x[31];
        e    = int'(x[30:23]);
        f    = x[22:0];
        if (e == 255) begin
            r.invalid = 1'b1;
            r.value   = (sign && f == 23'd0) ? 32'h80000000 : 32'h7FFFFFFF;
        end else if (e < 127) begin
            r.inexact = (e != 0) || (f != 23'd0);
        end else if (e <= 157) begin
            sig = {40'd0, 1'b1, f};
            k   = e - 127;
            if (k >= 23) begin
                mag = sig << (k - 23);
            end else begin
                mag       = sig >> (23 - k);
                r.inexact = (sig & ((64'd1 << (23 - k)) - 64'd1)) != 64'd0;
            end
            r.value = sign ? 32'(64'd0 - mag) : 32'(mag);
        end else if (sign && e == 158 && f == 23'd0) begin
            r.value = 32'h80000000;
        end else begin
            r.invalid = 1'b1;
            r.value   = sign ? 32'h80000000 : 32'h7FFFFFFF;
        end
        return r;
    endfunction

    function automatic ConvResult modelResult(input ConvRequest req);
        return req.toInt ? modelFloatToInt(req.operand) : modelIntToFloat(req.operand);
    endfunction

    // ########################################
    // result checking
    // ########################################

    task automatic checkResult(input ConvResult want);
        assert (result.value == want.value)
            else reportMismatch("result.value", 64'(want.value), 64'(result.value));
        assert (result.invalid == want.invalid)
            else reportMismatch("result.invalid", 64'(want.invalid), 64'(result.invalid));
        assert (result.inexact == want.inexact)
            else reportMismatch("result.inexact", 64'(want.inexact), 64'(result.inexact));
    endtask

    // outValid must follow inValid two cycles later, which also catches lost or extra results.
    always @(negedge clock) begin
        if (reset) begin
            validHistory = 2'b00;
            lastResult   = '0;
        end else begin
            assert (outValid == validHistory[1])
                else reportMismatch("outValid", 64'(validHistory[1]), 64'(outValid));
            if (outValid) begin
                assert (expectQueue.size() != 0)
                    else begin
                        $display("a result came out while no request was waiting for one");
                        stopWithFailure();
                    end
                expected = expectQueue.pop_front();
                checkResult(expected);
                lastResult = result;
            end else begin
                assert (result == lastResult)
                    else reportMismatch("result (held)", 64'(lastResult), 64'(result));
            end
            validHistory = {validHistory[0], inValid};
        end
    end

    // ########################################
    // stimulus
    // ########################################

    task automatic sendRequest(input logic toInt, input word32T operand, input ConvResult want);
        @(posedge clock);
        inValid         <= 1'b1;
        request.toInt   <= toInt;
        request.operand <= operand;
        expectQueue.push_back(want);
    endtask

    task automatic sendIdle();
        @(posedge clock);
        inValid         <= 1'b0;
        // the request bus carries junk while no strobe is given.
        request.toInt   <= 1'($random(seed));
        request.operand <= $random(seed);
    endtask

    task automatic waitForDrain();
        while (expectQueue.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic randomRequest(output ConvRequest req);
        word32T bits;
        int     shift;
        req.toInt = 1'($random(seed));
        bits      = $random(seed);
        if (req.toInt) begin
            // most floats land near the integer range so every branch gets hit.
            if ((($random(seed)) & 3) != 0) begin
                bits[30:23] = 8'd118 + 8'($unsigned($random(seed)) % 42);
            end
        end else begin
            shift = $unsigned($random(seed)) % 32;
            bits  = $signed(bits) >>> shift;
        end
        req.operand = bits;
    endtask

    task automatic checkIdleOutputs();
        assert (outValid == 1'b0)
            else reportMismatch("outValid", 64'd0, 64'(outValid));
        assert (result == '0)
            else reportMismatch("result", 64'd0, 64'(result));
    endtask

    // ########################################
    // tests
    // ########################################

    task automatic checkReset();
        // requests offered while reset is high must never come out.
        @(posedge clock);
        inValid <= 1'b1;
        repeat (4) begin
            @(negedge clock);
            checkIdleOutputs();
        end
        @(posedge clock);
        reset   <= 1'b0;
        inValid <= 1'b0;
        repeat (2) begin
            @(negedge clock);
            checkIdleOutputs();
        end
    endtask

    task automatic testIntToFloatDirected();
        sendRequest(1'b0, 32'h00000000, makeResult(32'h00000000, 1'b0, 1'b0));
        sendRequest(1'b0, 32'h00000001, makeResult(32'h3F800000, 1'b0, 1'b0));
        sendRequest(1'b0, 32'hFFFFFFFF, makeResult(32'hBF800000, 1'b0, 1'b0));
        sendRequest(1'b0, 32'h01000000, makeResult(32'h4B800000, 1'b0, 1'b0));
        sendRequest(1'b0, 32'h01000001, makeResult(32'h4B800000, 1'b0, 1'b1));
        sendRequest(1'b0, 32'h7FFFFFFF, makeResult(32'h4EFFFFFF, 1'b0, 1'b1));
        sendRequest(1'b0, 32'h80000000, makeResult(32'hCF000000, 1'b0, 1'b0));
        sendIdle();
        waitForDrain();
    endtask

    task automatic testFloatToIntDirected();
        sendRequest(1'b1, 32'h3F800000, makeResult(32'h00000001, 1'b0, 1'b0));
        sendRequest(1'b1, 32'hC0200000, makeResult(32'hFFFFFFFE, 1'b0, 1'b1));
        sendRequest(1'b1, 32'h3F400000, makeResult(32'h00000000, 1'b0, 1'b1));
        sendRequest(1'b1, 32'h4E800000, makeResult(32'h40000000, 1'b0, 1'b0));
        sendRequest(1'b1, 32'hCF000000, makeResult(32'h80000000, 1'b0, 1'b0));
        sendRequest(1'b1, 32'h00000001, makeResult(32'h00000000, 1'b0, 1'b1));
        sendIdle();
        waitForDrain();
    endtask

    task automatic testSaturation();
        sendRequest(1'b1, 32'h4F000000, makeResult(32'h7FFFFFFF, 1'b1, 1'b0));
        sendRequest(1'b1, 32'hCF800000, makeResult(32'h80000000, 1'b1, 1'b0));
        sendRequest(1'b1, 32'h7F800000, makeResult(32'h7FFFFFFF, 1'b1, 1'b0));
        sendRequest(1'b1, 32'hFF800000, makeResult(32'h80000000, 1'b1, 1'b0));
        sendRequest(1'b1, 32'h7FC00000, makeResult(32'h7FFFFFFF, 1'b1, 1'b0));
        sendRequest(1'b1, 32'hFFC00001, makeResult(32'h7FFFFFFF, 1'b1, 1'b0));
        sendIdle();
        waitForDrain();
    endtask

    task automatic testBackToBack();
        ConvRequest req;
        for (int i = 0; i < 200; i++) begin
            randomRequest(req);
            sendRequest(req.toInt, req.operand, modelResult(req));
        end
        sendIdle();
        waitForDrain();
    endtask

    task automatic testGaps();
        ConvRequest req;
        int         gap;
        for (int i = 0; i < 60; i++) begin
            randomRequest(req);
            sendRequest(req.toInt, req.operand, modelResult(req));
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) sendIdle();
        end
        sendIdle();
        waitForDrain();
    endtask

    initial begin
        seed       = 2;
        clock      = 1'b0;
        reset      = 1'b1;
        inValid    = 1'b0;
        request    = '0;
        cycleCount = 0;
        checkReset();
        testIntToFloatDirected();
        testFloatToIntDirected();
        testSaturation();
        testBackToBack();
        testGaps();
        repeat (3) @(negedge clock);
        if (expectQueue.size() != 0) begin
            $display("%0d expected results never came out", expectQueue.size());
            stopWithFailure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: verilog/FloatConv.sv
`timescale 1ns/1ns

module FloatConv (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     inValid,
    input  FloatConvPkg::ConvRequest request,
    output logic                     outValid,
    output FloatConvPkg::ConvResult  result
);

    import FloatConvPkg::*;

    logic       stageValid;
    ConvRequest stageRequest;
    ConvResult  toFloatResult;
    ConvResult  toIntResult;
    ConvResult  selected;

    // ########################################
    // stage 1, request register
    // ########################################

    always_ff @(posedge clock) begin
        if (reset) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= inValid;
        end
    end

    always_ff @(posedge clock) begin
        if (inValid) begin
            stageRequest <= request;
        end
    end

    // ########################################
    // converters and direction select
    // ########################################

    IntToFloat u_intToFloat (
        .operand (stageRequest.operand),
        .result  (toFloatResult)
    );

    FloatToInt u_floatToInt (
        .operand (stageRequest.operand),
        .result  (toIntResult)
    );

    assign selected = stageRequest.toInt ? toIntResult : toFloatResult;

    // ########################################
    // stage 2, result register
    // ########################################

    // the result only moves for a real request, so it holds between strobes.
    always_ff @(posedge clock) begin
        if (reset) begin
            outValid <= 1'b0;
            result   <= '0;
        end else begin
            outValid <= stageValid;
            if (stageValid) begin
                result <= selected;
            end
        end
    end

endmodule

// File: verilog/FloatConvPkg.sv
package FloatConvPkg;

    // ########################################
    // widths with a meaning
    // ########################################

    // a 32-bit operand or result, holding either an integer or float bits.
    typedef logic [31:0] word32T;

    typedef logic [7:0] shiftCountT;

    // leading-zero count, 0 to 32.
    typedef logic [5:0] leadCountT;

    typedef logic [7:0] exponentT;

    typedef logic [22:0] mantissaT;

    // ########################################
    // single-precision format constants
    // ########################################

    localparam exponentT ExpBias = 8'd127;

    // exponent shared by NaN and infinity.
    localparam exponentT ExpMax = 8'd255;

    localparam word32T IntMaxBits = 32'h7FFFFFFF;
    localparam word32T IntMinBits = 32'h80000000;

    // ########################################
    // request and result
    // ########################################

    typedef struct packed {
        logic   toInt;
        word32T operand;
    } ConvRequest;

    typedef struct packed {
        word32T value;
        logic   invalid;
        logic   inexact;
    } ConvResult;

endpackage

// File: verilog/FloatToInt.sv
`timescale 1ns/1ns

module FloatToInt (
    input  FloatConvPkg::word32T    operand,
    output FloatConvPkg::ConvResult result
);

    import FloatConvPkg::*;

    // smallest exponent whose value no longer fits below 2^31.
    localparam exponentT ExpIntLimit = ExpBias + 8'd31;

    logic       sign;
    exponentT   exponent;
    mantissaT   fraction;
    word32T     mantissaWord;
    shiftCountT shiftCount;
    word32T     shifted;
    word32T     lostMask;
    word32T     lostBits;

    // ########################################
    // unpack and align
    // ########################################

    assign {sign, exponent, fraction} = operand;

    assign mantissaWord = {1'b1, fraction, 8'h00};

    // only meaningful for exponents 127 to 157, where the count is 1 to 31.
    assign shiftCount = ExpIntLimit - exponent;

    ShiftR32U u_align (
        .n   (shiftCount),
        .in  (mantissaWord),
        .out (shifted)
    );

    assign lostMask = (word32T'(1) << shiftCount[4:0]) - word32T'(1);
    assign lostBits = mantissaWord & lostMask;

    // ########################################
    // classify the exponent range
    // ########################################

    always_comb begin
        result = '0;
        if (exponent == ExpMax) begin
            // every NaN saturates high, only -inf goes low.
            result.invalid = 1'b1;
            result.value   = (sign && fraction == '0) ? IntMinBits : IntMaxBits;
        end else if (exponent < ExpBias) begin
            result.inexact = (exponent != '0) || (fraction != '0);
        end else if (exponent < ExpIntLimit) begin
            result.value   = sign ? (~shifted + 32'd1) : shifted;
            result.inexact = |lostBits;
        end else if (sign && exponent == ExpIntLimit && fraction == '0) begin
            result.value = IntMinBits;
        end else begin
            result.invalid = 1'b1;
            result.value   = sign ? IntMinBits : IntMaxBits;
        end
    end

endmodule

// File: verilog/IntToFloat.sv
`timescale 1ns/1ns

module IntToFloat (
    input  FloatConvPkg::word32T    operand,
    output FloatConvPkg::ConvResult result
);

    import FloatConvPkg::*;

    // exponent of a value whose top bit sits at position 31.
    localparam exponentT ExpTopBit = ExpBias + 8'd31;

    logic       sign;
    word32T     magnitude;
    leadCountT  zeros;
    shiftCountT shiftCount;
    word32T     normalized;
    exponentT   exponent;
    mantissaT   fraction;

    // ########################################
    // magnitude and normalization
    // ########################################

    assign sign = operand[31];

    // negating -2^31 gives the same bits back, which read as 2^31 unsigned.
    assign magnitude = sign ? (~operand + 32'd1) : operand;

    LeadZero32 u_leadZero (
        .value (magnitude),
        .count (zeros)
    );

    assign shiftCount = {2'b00, zeros};

    ShiftL32U u_normalize (
        .n   (shiftCount),
        .in  (magnitude),
        .out (normalized)
    );

    // ########################################
    // packing
    // ########################################

    assign exponent = ExpTopBit - {2'b00, zeros};

    // bit 31 of the normalized word is the hidden one.
    assign fraction = normalized[30:8];

    always_comb begin
        result = '0;
        if (operand != '0) begin
            result.value   = {sign, exponent, fraction};
            result.inexact = |normalized[7:0];
        end
    end

endmodule

// File: verilog/LeadZero32.sv
`timescale 1ns/1ns

module LeadZero32 (
    input  FloatConvPkg::word32T    value,
    output FloatConvPkg::leadCountT count
);

    import FloatConvPkg::*;

    localparam leadCountT AllZeroCount = 6'd32;

    logic [3:0] byteHit;
    logic [1:0] topByte;
    logic [7:0] selByte;
    logic [2:0] bitZeros;

    // the search runs in two steps, first the highest nonzero byte.
    assign byteHit = {|value[31:24], |value[23:16], |value[15:8], |value[7:0]};

    always_comb begin
        topByte = 2'd0;
        for (int b = 0; b < 4; b++) begin
            if (byteHit[b]) begin
                topByte = 2'(b);
            end
        end
    end

    assign selByte = value[{topByte, 3'b000} +: 8];

    // then the highest one bit inside that byte.
    always_comb begin
        bitZeros = 3'd0;
        for (int k = 0; k < 8; k++) begin
            if (selByte[k]) begin
                bitZeros = 3'(7 - k);
            end
        end
    end

    // whole bytes above the hit count eight zeros each.
    assign count = (byteHit == 4'b0000) ? AllZeroCount
                                        : {1'b0, 2'd3 - topByte, bitZeros};

endmodule

// File: verilog/Shift32U.sv
`timescale 1ns/1ns

// logical left shift, built as a five stage barrel shifter.
module ShiftL32U (
    input  FloatConvPkg::shiftCountT n,
    input  FloatConvPkg::word32T     in,
    output FloatConvPkg::word32T     out
);

    import FloatConvPkg::*;

    word32T stage1;
    word32T stage2;
    word32T stage4;
    word32T stage8;
    word32T stage16;

    assign stage1  = n[0] ? {in[30:0], 1'b0} : in;
    assign stage2  = n[1] ? {stage1[29:0], 2'b0} : stage1;
    assign stage4  = n[2] ? {stage2[27:0], 4'b0} : stage2;
    assign stage8  = n[3] ? {stage4[23:0], 8'b0} : stage4;
    assign stage16 = n[4] ? {stage8[15:0], 16'b0} : stage8;

    // a count of 32 or more pushes every bit out.
    assign out = (n[7:5] != 3'b000) ? '0 : stage16;

endmodule

// logical right shift, the mirror of ShiftL32U.
module ShiftR32U (
    input  FloatConvPkg::shiftCountT n,
    input  FloatConvPkg::word32T     in,
    output FloatConvPkg::word32T     out
);

    import FloatConvPkg::*;

    word32T stage1;
    word32T stage2;
    word32T stage4;
    word32T stage8;
    word32T stage16;

    assign stage1  = n[0] ? {1'b0, in[31:1]} : in;
    assign stage2  = n[1] ? {2'b0, stage1[31:2]} : stage1;
    assign stage4  = n[2] ? {4'b0, stage2[31:4]} : stage2;
    assign stage8  = n[3] ? {8'b0, stage4[31:8]} : stage4;
    assign stage16 = n[4] ? {16'b0, stage8[31:16]} : stage8;

    assign out = (n[7:5] != 3'b000) ? '0 : stage16;

endmodule
